//--- src/i2c_tgt_pkg.sv
// Shared widths, FIFO depth, descriptor layout and FIFO entry type for the standby I2C target
`default_nettype none

package i2c_tgt_pkg;

    // Receive FIFO between bus side and TTI side
    localparam int RxFifoDepth = 8;

    // TTI RX data word and descriptor width
    localparam int TtiDataWidth = 32;

    // Descriptor layout
    localparam int DescCountWidth = 16;
    localparam int DescOverflowBit = 31;

    // One FIFO entry, either a data byte or an end-of-transfer token
    typedef struct packed {
        logic [7:0] data;
        // Token closing a transfer, data unused
        logic       eot;
        // Valid in tokens only
        logic       overflow;
    } rx_entry_t;

endpackage

`default_nettype wire

//--- src/rx_byte_if.sv
// Valid/ready link that carries received bytes and end-of-transfer tokens between blocks
`default_nettype none

interface rx_byte_if
    import i2c_tgt_pkg::*;
();

    logic      valid;
    logic      ready;
    rx_entry_t entry;

    // Entry held stable while valid and not ready
    modport source (
        output valid,
        output entry,
        input  ready
    );

    modport sink (
        input  valid,
        input  entry,
        output ready
    );

endinterface

`default_nettype wire

//--- src/i2c_target_rx.sv
// Bus side of the standby I2C target that decodes bus conditions, ACKs writes and pushes bytes
`default_nettype none

module i2c_target_rx
    import i2c_tgt_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       ctrl_scl_i,
    input  logic       ctrl_sda_i,
    output logic       ctrl_scl_o,
    output logic       ctrl_sda_o,
    input  logic [6:0] target_sta_addr_i,
    input  logic       target_sta_addr_valid_i,
    output logic       bus_start_o,
    output logic       bus_rstart_o,
    output logic       bus_stop_o,
    output logic [7:0] bus_addr_o,
    output logic       bus_addr_valid_o,
    rx_byte_if.source  byte_o
);

    typedef enum logic [2:0] {
        StIdle,
        StAddr,
        StAddrAck,
        StData,
        StDataAck,
        StIgnore
    } state_e;

    state_e     state_q;
    logic       scl_q1, scl_q2, scl_q3;
    logic       sda_q1, sda_q2, sda_q3;
    logic       start_det, stop_det, scl_rise, scl_fall;
    logic       bus_busy_q;
    logic [3:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic [7:0] byte_q;
    logic [7:0] rx_byte;
    logic       last_bit;
    logic       addr_match;
    logic       ack_q;
    logic       xfer_q;
    logic       ovf_q;
    logic       byte_pend_q;
    logic       tok_pend_q;
    logic       tok_ovf_q;
    rx_entry_t  entry_d;

    // Two-flop sync plus one stage of history for edge detection
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            {scl_q1, scl_q2, scl_q3} <= 3'b111;
            {sda_q1, sda_q2, sda_q3} <= 3'b111;
            bus_start_o  <= 1'b0;
            bus_rstart_o <= 1'b0;
            bus_stop_o   <= 1'b0;
        end else begin
            {scl_q1, scl_q2, scl_q3} <= {ctrl_scl_i, scl_q1, scl_q2};
            {sda_q1, sda_q2, sda_q3} <= {ctrl_sda_i, sda_q1, sda_q2};
            bus_start_o  <= start_det && !bus_busy_q;
            bus_rstart_o <= start_det && bus_busy_q;
            bus_stop_o   <= stop_det;
        end
    end

    assign start_det = scl_q2 && scl_q3 && sda_q3 && !sda_q2;
    assign stop_det  = scl_q2 && scl_q3 && !sda_q3 && sda_q2;
    assign scl_rise  = scl_q2 && !scl_q3;
    assign scl_fall  = !scl_q2 && scl_q3;

    assign rx_byte    = {shift_q[6:0], sda_q2};
    assign last_bit   = scl_rise && bit_cnt_q == 4'd7;
    assign addr_match = target_sta_addr_valid_i && rx_byte[7:1] == target_sta_addr_i
                        && !rx_byte[0] && !tok_pend_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q          <= StIdle;
            bit_cnt_q        <= '0;
            bus_busy_q       <= 1'b0;
            bus_addr_valid_o <= 1'b0;
            ack_q            <= 1'b0;
            xfer_q           <= 1'b0;
            ovf_q            <= 1'b0;
            byte_pend_q      <= 1'b0;
            tok_pend_q       <= 1'b0;
            tok_ovf_q        <= 1'b0;
        end else begin
            byte_pend_q      <= 1'b0;
            bus_addr_valid_o <= 1'b0;
            if (tok_pend_q && byte_o.ready) begin
                tok_pend_q <= 1'b0;
            end
            // A full FIFO means drop and NACK
            if (byte_pend_q) begin
                ack_q <= byte_o.ready;
                if (!byte_o.ready) begin
                    ovf_q <= 1'b1;
                end
            end
            if (start_det || stop_det) begin
                state_q    <= start_det ? StAddr : StIdle;
                bit_cnt_q  <= '0;
                bus_busy_q <= start_det;
                xfer_q     <= 1'b0;
                ovf_q      <= 1'b0;
                if (xfer_q) begin
                    tok_pend_q <= 1'b1;
                    tok_ovf_q  <= ovf_q;
                end
            end else begin
                case (state_q)
                    StAddr, StData: begin
                        if (scl_rise && bit_cnt_q != 4'd8) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end else if (scl_fall && bit_cnt_q == 4'd8) begin
                            state_q <= (state_q == StAddr) ? StAddrAck : StDataAck;
                        end
                        if (last_bit && state_q == StAddr) begin
                            ack_q            <= addr_match;
                            bus_addr_valid_o <= 1'b1;
                        end
                        if (last_bit && state_q == StData) begin
                            byte_pend_q <= 1'b1;
                        end
                    end
                    StAddrAck: begin
                        if (scl_fall) begin
                            bit_cnt_q <= '0;
                            xfer_q    <= ack_q;
                            state_q   <= ack_q ? StData : StIgnore;
                        end
                    end
                    StDataAck: begin
                        if (scl_fall) begin
                            bit_cnt_q <= '0;
                            state_q   <= StData;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (scl_rise) begin
            shift_q <= rx_byte;
        end
        if (last_bit && state_q == StAddr) begin
            bus_addr_o <= rx_byte;
        end
        if (last_bit) begin
            byte_q <= rx_byte;
        end
    end

    // Token has priority over a data byte
    // A byte goes out only when the FIFO takes it at once
    always_comb begin
        entry_d.data     = tok_pend_q ? 8'h00 : byte_q;
        entry_d.eot      = tok_pend_q;
        entry_d.overflow = tok_pend_q && tok_ovf_q;
    end

    assign byte_o.entry = entry_d;
    assign byte_o.valid = tok_pend_q || (byte_pend_q && byte_o.ready);

    assign ctrl_scl_o = 1'b1;
    assign ctrl_sda_o = !(ack_q && (state_q == StAddrAck || state_q == StDataAck));

    // ACK drive starts only at a synchronized SCL fall
    a_sda_low_at_scl_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(ctrl_sda_o) |-> $past(scl_fall));

    a_entry_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        byte_o.valid && !byte_o.ready |=> byte_o.valid && $stable(byte_o.entry));

endmodule

`default_nettype wire

//--- src/rx_byte_fifo.sv
// Circular buffer between the bus receiver and the TTI packer, one cycle first-word latency
`default_nettype none

module rx_byte_fifo
    import i2c_tgt_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    rx_byte_if.sink   wr_o,
    rx_byte_if.source rd_o
);

    rx_entry_t                          mem_q [RxFifoDepth];
    logic [$clog2(RxFifoDepth)-1:0]     wr_ptr_q;
    logic [$clog2(RxFifoDepth)-1:0]     rd_ptr_q;
    logic [$clog2(RxFifoDepth + 1)-1:0] fill_q;
    logic                               push;
    logic                               pop;

    assign wr_o.ready = fill_q != RxFifoDepth;
    assign rd_o.valid = fill_q != 0;
    assign rd_o.entry = mem_q[rd_ptr_q];

    assign push = wr_o.valid && wr_o.ready;
    assign pop  = rd_o.valid && rd_o.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == RxFifoDepth - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == RxFifoDepth - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the fill unchanged
            if (push && !pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop && !push) begin
                fill_q <= fill_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_o.entry;
        end
    end

    a_fill_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fill_q <= RxFifoDepth);

    // An empty FIFO can only gain entries
    a_fill_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fill_q == 0 |=> fill_q <= 1);

endmodule

`default_nettype wire

//--- src/tti_rx_packer.sv
// TTI side packer, turns FIFO bytes into RX data words and one RX descriptor per transfer
`default_nettype none

module tti_rx_packer
    import i2c_tgt_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    rx_byte_if.sink                 byte_i,
    output logic                    rx_queue_wvalid_o,
    input  logic                    rx_queue_wready_i,
    output logic [TtiDataWidth-1:0] rx_queue_wdata_o,
    output logic                    rx_desc_queue_wvalid_o,
    input  logic                    rx_desc_queue_wready_i,
    output logic [TtiDataWidth-1:0] rx_desc_queue_wdata_o
);

    logic [TtiDataWidth-1:0]   word_q;
    logic [TtiDataWidth-1:0]   word_nxt;
    logic [TtiDataWidth-1:0]   wdata_q;
    logic [TtiDataWidth-1:0]   desc_q;
    logic [TtiDataWidth-1:0]   desc_nxt;
    logic [1:0]                lane_q;
    logic [DescCountWidth-1:0] count_q;
    logic                      word_vld_q;
    logic                      desc_pend_q;
    logic                      pop;

    // Stall the FIFO while anything is waiting on a queue
    assign byte_i.ready = !word_vld_q && !desc_pend_q;
    assign pop          = byte_i.valid && byte_i.ready;

    always_comb begin
        word_nxt                 = word_q;
        word_nxt[8*lane_q +: 8] = byte_i.entry.data;
    end

    always_comb begin
        desc_nxt                       = '0;
        desc_nxt[DescCountWidth-1:0]   = count_q;
        desc_nxt[DescOverflowBit]      = byte_i.entry.overflow;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            word_q      <= '0;
            lane_q      <= '0;
            count_q     <= '0;
            word_vld_q  <= 1'b0;
            desc_pend_q <= 1'b0;
        end else begin
            if (word_vld_q && rx_queue_wready_i) begin
                word_vld_q <= 1'b0;
            end
            if (rx_desc_queue_wvalid_o && rx_desc_queue_wready_i) begin
                desc_pend_q <= 1'b0;
            end
            if (pop && byte_i.entry.eot) begin
                // Flush a partial word, descriptor follows once it is taken
                word_vld_q  <= lane_q != 2'd0;
                desc_pend_q <= 1'b1;
                word_q      <= '0;
                lane_q      <= '0;
                count_q     <= '0;
            end else if (pop) begin
                count_q <= count_q + 1'b1;
                lane_q  <= lane_q + 1'b1;
                if (lane_q == 2'd3) begin
                    word_vld_q <= 1'b1;
                    word_q     <= '0;
                end else begin
                    word_q <= word_nxt;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop && byte_i.entry.eot) begin
            wdata_q <= word_q;
            desc_q  <= desc_nxt;
        end else if (pop && lane_q == 2'd3) begin
            wdata_q <= word_nxt;
        end
    end

    assign rx_queue_wvalid_o      = word_vld_q;
    assign rx_queue_wdata_o       = wdata_q;
    assign rx_desc_queue_wvalid_o = desc_pend_q && !word_vld_q;
    assign rx_desc_queue_wdata_o  = desc_q;

    a_word_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rx_queue_wvalid_o && !rx_queue_wready_i |=> $stable(rx_queue_wdata_o));

    a_desc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rx_desc_queue_wvalid_o && !rx_desc_queue_wready_i |=> $stable(rx_desc_queue_wdata_o));

endmodule

`default_nettype wire

//--- src/i2c_standby_target.sv
// Top level of the standby I2C target write path, from the bus pins to the TTI RX queues
`default_nettype none

module i2c_standby_target
    import i2c_tgt_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    ctrl_scl_i,
    input  logic                    ctrl_sda_i,
    output logic                    ctrl_scl_o,
    output logic                    ctrl_sda_o,
    input  logic [6:0]              target_sta_addr_i,
    input  logic                    target_sta_addr_valid_i,
    output logic                    bus_start_o,
    output logic                    bus_rstart_o,
    output logic                    bus_stop_o,
    output logic [7:0]              bus_addr_o,
    output logic                    bus_addr_valid_o,
    output logic                    rx_queue_wvalid_o,
    input  logic                    rx_queue_wready_i,
    output logic [TtiDataWidth-1:0] rx_queue_wdata_o,
    output logic                    rx_desc_queue_wvalid_o,
    input  logic                    rx_desc_queue_wready_i,
    output logic [TtiDataWidth-1:0] rx_desc_queue_wdata_o
);

    rx_byte_if rx_to_fifo ();
    rx_byte_if fifo_to_packer ();

    i2c_target_rx i_target_rx (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .ctrl_scl_i             (ctrl_scl_i),
        .ctrl_sda_i             (ctrl_sda_i),
        .ctrl_scl_o             (ctrl_scl_o),
        .ctrl_sda_o             (ctrl_sda_o),
        .target_sta_addr_i      (target_sta_addr_i),
        .target_sta_addr_valid_i(target_sta_addr_valid_i),
        .bus_start_o            (bus_start_o),
        .bus_rstart_o           (bus_rstart_o),
        .bus_stop_o             (bus_stop_o),
        .bus_addr_o             (bus_addr_o),
        .bus_addr_valid_o       (bus_addr_valid_o),
        .byte_o                 (rx_to_fifo)
    );

    rx_byte_fifo i_fifo (
        .clk_i (clk_i),
        .rst_ni(rst_ni),
        .wr_o  (rx_to_fifo),
        .rd_o  (fifo_to_packer)
    );

    tti_rx_packer i_packer (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .byte_i                (fifo_to_packer),
        .rx_queue_wvalid_o     (rx_queue_wvalid_o),
        .rx_queue_wready_i     (rx_queue_wready_i),
        .rx_queue_wdata_o      (rx_queue_wdata_o),
        .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
        .rx_desc_queue_wready_i(rx_desc_queue_wready_i),
        .rx_desc_queue_wdata_o (rx_desc_queue_wdata_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_i2c_standby_target.sv
// Testbench that runs an I2C host model over a table of transfers against the standby target
`default_nettype none

module tb_i2c_standby_target
    import i2c_tgt_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          HalfScl      = 8;
    localparam int          NumXfers     = 9;
    localparam int          MarginCycles = 4000;
    localparam logic [6:0]  StaAddr      = 7'h3c;
    localparam logic [31:0] Seed         = 32'h48d5_85eb;
    localparam logic [1:0]  StallNone    = 2'd0;
    localparam logic [1:0]  StallData    = 2'd1;
    localparam logic [1:0]  StallRandom  = 2'd2;

    typedef struct packed {
        logic [6:0] addr;
        logic       rnw;
        logic [7:0] nbytes;
        logic [1:0] stall;
        logic       rstart;
        logic       ack;
    } xfer_t;

    // Row 7 joins row 6 by a repeated START
    localparam xfer_t Xfers [NumXfers] = '{
        '{StaAddr, 1'b0, 8'd1,  StallNone,   1'b0, 1'b1},
        '{StaAddr, 1'b0, 8'd4,  StallNone,   1'b0, 1'b1},
        '{StaAddr, 1'b0, 8'd7,  StallNone,   1'b0, 1'b1},
        '{7'h2b,   1'b0, 8'd2,  StallNone,   1'b0, 1'b0},
        '{StaAddr, 1'b1, 8'd0,  StallNone,   1'b0, 1'b0},
        '{StaAddr, 1'b0, 8'd20, StallData,   1'b0, 1'b1},
        '{StaAddr, 1'b0, 8'd5,  StallNone,   1'b0, 1'b1},
        '{StaAddr, 1'b0, 8'd6,  StallNone,   1'b1, 1'b1},
        '{StaAddr, 1'b0, 8'd11, StallRandom, 1'b0, 1'b1}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    logic        host_scl, host_sda, scl_bus, sda_bus, scl_drv, sda_drv;
    logic [6:0]  sta_addr;
    logic        sta_addr_valid;
    logic        bus_start, bus_rstart, bus_stop, bus_addr_valid;
    logic [7:0]  bus_addr;
    logic        rxq_valid, descq_valid;
    logic        rxq_ready = 1'b1;
    logic        descq_ready = 1'b1;
    logic [31:0] rxq_data, descq_data;
    logic [1:0]  stall_mode = StallNone;
    logic [31:0] data_rng = Seed;
    logic [31:0] stall_rng = Seed;
    int          errors = 0;
    int          n_start = 0, n_rstart = 0, n_stop = 0;
    int          exp_start = 0, exp_rstart = 0, exp_stop = 0;
    logic [7:0]  seen_addrs [$];
    logic [7:0]  exp_addrs [$];
    logic [31:0] got_words [$], got_descs [$], exp_words [$], exp_descs [$];

    // Open-drain bus as wired-AND of host and target
    assign scl_bus = host_scl & scl_drv;
    assign sda_bus = host_sda & sda_drv;

    i2c_standby_target i_dut (
        .clk_i                  (clk),
        .rst_ni                 (rst_n),
        .ctrl_scl_i             (scl_bus),
        .ctrl_sda_i             (sda_bus),
        .ctrl_scl_o             (scl_drv),
        .ctrl_sda_o             (sda_drv),
        .target_sta_addr_i      (sta_addr),
        .target_sta_addr_valid_i(sta_addr_valid),
        .bus_start_o            (bus_start),
        .bus_rstart_o           (bus_rstart),
        .bus_stop_o             (bus_stop),
        .bus_addr_o             (bus_addr),
        .bus_addr_valid_o       (bus_addr_valid),
        .rx_queue_wvalid_o      (rxq_valid),
        .rx_queue_wready_i      (rxq_ready),
        .rx_queue_wdata_o       (rxq_data),
        .rx_desc_queue_wvalid_o (descq_valid),
        .rx_desc_queue_wready_i (descq_ready),
        .rx_desc_queue_wdata_o  (descq_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int run_limit();
        int bits;
        bits = 0;
        for (int r = 0; r < NumXfers; r++) begin
            bits += 9 * (int'(Xfers[r].nbytes) + 1) + 2;
        end
        return bits * 16 + 10 + MarginCycles;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_start(input logic repeated);
        if (repeated) begin
            wait_clocks(HalfScl / 2);
            host_sda = 1'b1;
            wait_clocks(HalfScl / 2);
            host_scl = 1'b1;
            wait_clocks(HalfScl);
        end
        host_sda = 1'b0;
        wait_clocks(HalfScl);
        host_scl = 1'b0;
    endtask

    // SDA changes mid-low and is sampled mid-high
    task automatic send_bit(input logic b, output logic sampled);
        wait_clocks(HalfScl / 2);
        host_sda = b;
        wait_clocks(HalfScl / 2);
        host_scl = 1'b1;
        wait_clocks(HalfScl / 2);
        sampled = sda_bus;
        wait_clocks(HalfScl / 2);
        host_scl = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic s;
        for (int i = 7; i >= 0; i--) begin
            send_bit(b[i], s);
        end
        send_bit(1'b1, s);
        ack = !s;
    endtask

    task automatic send_stop();
        wait_clocks(HalfScl / 2);
        host_sda = 1'b0;
        wait_clocks(HalfScl / 2);
        host_scl = 1'b1;
        wait_clocks(HalfScl);
        host_sda = 1'b1;
        wait_clocks(HalfScl);
    endtask

    task automatic wait_for_descs();
        while (got_descs.size() < exp_descs.size()) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Pulse and address monitor
    always @(negedge clk) begin
        if (bus_start) n_start++;
        if (bus_rstart) n_rstart++;
        if (bus_stop) n_stop++;
        if (bus_addr_valid) seen_addrs.push_back(bus_addr);
        // Target never stretches the clock
        check_val("ctrl_scl_o", 32'(scl_drv), 32'd1);
    end

    // TTI queue models
    always @(posedge clk) begin
        if (rxq_valid && rxq_ready) got_words.push_back(rxq_data);
        if (descq_valid && descq_ready) got_descs.push_back(descq_data);
    end

    always @(negedge clk) begin
        stall_rng = xorshift32(stall_rng);
        case (stall_mode)
            StallData: begin
                rxq_ready = 1'b0;
                descq_ready = 1'b1;
            end
            StallRandom: begin
                rxq_ready = stall_rng[0];
                descq_ready = stall_rng[1];
            end
            default: begin
                rxq_ready = 1'b1;
                descq_ready = 1'b1;
            end
        endcase
    end

    initial begin : watchdog
        int limit;
        int cycles;
        limit = run_limit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d errors", cycles, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        logic        ack, exp_ack, ovf;
        logic [7:0]  b;
        logic [31:0] word, desc;
        int          lane, acked;
        host_scl = 1'b1;
        host_sda = 1'b1;
        rst_n = 1'b0;
        sta_addr = StaAddr;
        sta_addr_valid = 1'b1;
        wait_clocks(10);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("ctrl_sda_o after reset", 32'(sda_drv), 32'd1);
        check_val("rx_queue_wvalid_o after reset", 32'(rxq_valid), 32'd0);
        check_val("rx_desc_queue_wvalid_o after reset", 32'(descq_valid), 32'd0);

        for (int r = 0; r < NumXfers; r++) begin
            send_start(Xfers[r].rstart);
            if (Xfers[r].rstart) exp_rstart++;
            else exp_start++;
            exp_addrs.push_back({Xfers[r].addr, Xfers[r].rnw});
            send_byte({Xfers[r].addr, Xfers[r].rnw}, ack);
            check_val("ctrl_sda_o address ack", 32'(ack), 32'(Xfers[r].ack));
            stall_mode = Xfers[r].stall;
            word = '0;
            lane = 0;
            acked = 0;
            ovf = 1'b0;
            for (int i = 0; i < int'(Xfers[r].nbytes); i++) begin
                data_rng = xorshift32(data_rng);
                b = data_rng[7:0];
                // Held data queue backs up into packer word plus FIFO
                exp_ack = Xfers[r].ack && (Xfers[r].stall != StallData || i < 4 + RxFifoDepth);
                send_byte(b, ack);
                check_val("ctrl_sda_o data ack", 32'(ack), 32'(exp_ack));
                if (exp_ack) begin
                    word[8*lane +: 8] = b;
                    lane++;
                    acked++;
                    if (lane == 4) begin
                        exp_words.push_back(word);
                        word = '0;
                        lane = 0;
                    end
                end else begin
                    ovf = 1'b1;
                end
            end
            if (Xfers[r].ack) begin
                if (lane != 0) exp_words.push_back(word);
                desc = '0;
                desc[DescCountWidth-1:0] = acked[DescCountWidth-1:0];
                desc[DescOverflowBit] = ovf;
                exp_descs.push_back(desc);
            end
            if (r == NumXfers - 1 || !Xfers[r + 1].rstart) begin
                send_stop();
                exp_stop++;
                if (stall_mode == StallData) stall_mode = StallNone;
                wait_for_descs();
                stall_mode = StallNone;
                check_val("rx_queue word count", got_words.size(), exp_words.size());
            end
        end

        wait_clocks(20);
        check_val("bus_start_o pulses", n_start, exp_start);
        check_val("bus_rstart_o pulses", n_rstart, exp_rstart);
        check_val("bus_stop_o pulses", n_stop, exp_stop);
        check_val("bus_addr_valid_o pulses", seen_addrs.size(), exp_addrs.size());
        check_val("rx_desc_queue count", got_descs.size(), exp_descs.size());
        for (int i = 0; i < exp_addrs.size() && i < seen_addrs.size(); i++) begin
            check_val("bus_addr_o", 32'(seen_addrs[i]), 32'(exp_addrs[i]));
        end
        for (int i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
            check_val("rx_queue_wdata_o", got_words[i], exp_words[i]);
        end
        for (int i = 0; i < exp_descs.size() && i < got_descs.size(); i++) begin
            check_val("rx_desc_queue_wdata_o", got_descs[i], exp_descs[i]);
        end

        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
src/i2c_tgt_pkg.sv
src/rx_byte_if.sv
src/i2c_target_rx.sv
src/rx_byte_fifo.sv
src/tti_rx_packer.sv
src/i2c_standby_target.sv
sim/tb_i2c_standby_target.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and scan the log for failure

cd "$(dirname "$0")" || exit 1

TOP=tb_i2c_standby_target
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module "$TOP" -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
